// ==== psum_params.svh ====
`ifndef PSUM_PARAMS_SVH
`define PSUM_PARAMS_SVH

// loop counter widths, one per layer shape field.
`define PSUM_F_WIDTH    4
`define PSUM_M_WIDTH    6
`define PSUM_N_WIDTH    3
`define PSUM_E_WIDTH    3
`define PSUM_P_WIDTH    3
`define PSUM_T_WIDTH    2

// psum word returned by the array for each index tuple.
`define PSUM_DATA_WIDTH 16

// accumulator entries are wider so that long runs do not wrap early.
`define PSUM_ACC_WIDTH  24

// host configuration data bus.
`define PSUM_CFG_WIDTH  8

// one entry per output row and column, rows times columns.
`define PSUM_BUF_DEPTH  128

`endif

// ==== psum_pkg.sv ====
`include "psum_params.svh"

package psum_pkg;

    // index generator FSM states.
    typedef enum logic [1:0] {
        IDLE,
        INNER_LOOP,
        OUTER_LOOP,
        DONE
    } gen_state_e;

    // host configuration opcodes, one per shape field plus the run command.
    typedef enum logic [2:0] {
        CFG_F     = 3'd0,
        CFG_M     = 3'd1,
        CFG_N     = 3'd2,
        CFG_E     = 3'd3,
        CFG_P     = 3'd4,
        CFG_T     = 3'd5,
        CFG_START = 3'd6
    } cfg_op_e;

    // buffer address is the row index on top of the column index.
    typedef logic [`PSUM_E_WIDTH+`PSUM_F_WIDTH-1:0] buf_addr_t;

    typedef logic [`PSUM_ACC_WIDTH-1:0] acc_t;
    typedef logic [`PSUM_DATA_WIDTH-1:0] psum_t;

endpackage

// ==== layer_config_regs.sv ====
`timescale 1ns/10ps
`include "psum_params.svh"

module layer_config_regs
    import psum_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        i_cfg_strobe,
    input  cfg_op_e                     i_cfg_op,
    input  logic [`PSUM_CFG_WIDTH-1:0]  i_cfg_data,
    input  logic                        i_gen_busy,
    output logic [`PSUM_F_WIDTH-1:0]    o_shape_f,
    output logic [`PSUM_M_WIDTH-1:0]    o_shape_m,
    output logic [`PSUM_N_WIDTH-1:0]    o_shape_n,
    output logic [`PSUM_E_WIDTH-1:0]    o_shape_e,
    output logic [`PSUM_P_WIDTH-1:0]    o_shape_p,
    output logic [`PSUM_T_WIDTH-1:0]    o_shape_t,
    output logic                        o_start,
    output logic                        o_cfg_error
);

    localparam int M_W = `PSUM_M_WIDTH;

    logic [`PSUM_M_WIDTH-1:0] pass_span;
    logic                     shape_ok;
    logic                     start_req;
    logic                     start_ok;

    assign pass_span = M_W'(o_shape_p) * M_W'(o_shape_t); // channels covered by one pass.
    assign shape_ok  = (o_shape_f != '0) && (o_shape_m != '0) && (o_shape_n != '0) &&
                       (o_shape_e != '0) && (o_shape_p != '0) && (o_shape_t != '0) &&
                       (pass_span <= o_shape_m);
    assign start_req = i_cfg_strobe && (i_cfg_op == CFG_START);

    // a start still in flight counts as busy, since the generator only sees it next cycle.
    assign start_ok = shape_ok && !i_gen_busy && !o_start;

    always_ff @(posedge clk) begin
        if (reset) begin
            o_shape_f <= '0;
            o_shape_m <= '0;
            o_shape_n <= '0;
            o_shape_e <= '0;
            o_shape_p <= '0;
            o_shape_t <= '0;
        end else if (i_cfg_strobe) begin
            case (i_cfg_op)
                CFG_F:   o_shape_f <= i_cfg_data[`PSUM_F_WIDTH-1:0];
                CFG_M:   o_shape_m <= i_cfg_data[`PSUM_M_WIDTH-1:0];
                CFG_N:   o_shape_n <= i_cfg_data[`PSUM_N_WIDTH-1:0];
                CFG_E:   o_shape_e <= i_cfg_data[`PSUM_E_WIDTH-1:0];
                CFG_P:   o_shape_p <= i_cfg_data[`PSUM_P_WIDTH-1:0];
                CFG_T:   o_shape_t <= i_cfg_data[`PSUM_T_WIDTH-1:0];
                default: ; // the start command leaves the shape alone.
            endcase
        end
    end

    // exactly one of the two pulses follows every start command.
    always_ff @(posedge clk) begin
        if (reset) begin
            o_start     <= 1'b0;
            o_cfg_error <= 1'b0;
        end else begin
            o_start     <= start_req && start_ok;
            o_cfg_error <= start_req && !start_ok;
        end
    end

endmodule

// ==== psum_index_generator.sv ====
`timescale 1ns/10ps
`include "psum_params.svh"

module psum_index_generator
    import psum_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        i_start,
    input  logic                        i_await,
    input  logic [`PSUM_F_WIDTH-1:0]    i_f,
    input  logic [`PSUM_M_WIDTH-1:0]    i_m,
    input  logic [`PSUM_N_WIDTH-1:0]    i_n,
    input  logic [`PSUM_E_WIDTH-1:0]    i_e,
    input  logic [`PSUM_P_WIDTH-1:0]    i_p,
    input  logic [`PSUM_T_WIDTH-1:0]    i_t,
    output logic                        o_busy,
    output logic                        o_done,
    output logic                        o_idx_valid,
    output logic [`PSUM_N_WIDTH-1:0]    o_psum_index,
    output logic [`PSUM_M_WIDTH-1:0]    o_channel_index,
    output logic [`PSUM_E_WIDTH-1:0]    o_row_index,
    output logic [`PSUM_F_WIDTH-1:0]    o_col_index
);

    localparam int M_W = `PSUM_M_WIDTH;

    gen_state_e state_crnt, state_nxt;

    logic [`PSUM_F_WIDTH-1:0] f_crnt, f_nxt;
    logic [`PSUM_N_WIDTH-1:0] n_crnt, n_nxt;
    logic [`PSUM_E_WIDTH-1:0] e_crnt, e_nxt;
    logic [`PSUM_P_WIDTH-1:0] p_crnt, p_nxt;
    logic [`PSUM_T_WIDTH-1:0] t_crnt, t_nxt;
    logic [`PSUM_M_WIDTH-1:0] base_crnt, base_nxt;

    logic                     p_last;
    logic                     f_last;
    logic                     n_last;
    logic                     t_last;
    logic                     e_last;
    logic [`PSUM_M_WIDTH-1:0] base_step;
    logic [`PSUM_M_WIDTH-1:0] group_offset;

    assign p_last = (p_crnt == i_p - 1'b1);
    assign f_last = (f_crnt == i_f - 1'b1);
    assign n_last = (n_crnt == i_n - 1'b1);
    assign t_last = (t_crnt == i_t - 1'b1);
    assign e_last = (e_crnt == i_e - 1'b1);

    assign base_step    = base_crnt + M_W'(i_p) * M_W'(i_t); // next pass starts here.
    assign group_offset = M_W'(t_crnt) * M_W'(i_p);

    always_ff @(posedge clk) begin
        if (reset) begin
            state_crnt <= IDLE;
            f_crnt     <= '0;
            n_crnt     <= '0;
            e_crnt     <= '0;
            p_crnt     <= '0;
            t_crnt     <= '0;
            base_crnt  <= '0;
        end else begin
            state_crnt <= state_nxt;
            f_crnt     <= f_nxt;
            n_crnt     <= n_nxt;
            e_crnt     <= e_nxt;
            p_crnt     <= p_nxt;
            t_crnt     <= t_nxt;
            base_crnt  <= base_nxt;
        end
    end

    always_comb begin
        state_nxt = state_crnt;
        f_nxt     = f_crnt;
        n_nxt     = n_crnt;
        e_nxt     = e_crnt;
        p_nxt     = p_crnt;
        t_nxt     = t_crnt;
        base_nxt  = base_crnt;
        case (state_crnt)
            IDLE: begin
                if (i_start) begin
                    state_nxt = INNER_LOOP;
                    f_nxt     = '0;
                    n_nxt     = '0;
                    e_nxt     = '0;
                    p_nxt     = '0;
                    t_nxt     = '0;
                end
            end
            INNER_LOOP: begin
                // one tuple per unstalled cycle, p fastest, then F, then n.
                if (!i_await) begin
                    p_nxt = p_last ? '0 : p_crnt + 1'b1;
                    if (p_last) begin
                        f_nxt = f_last ? '0 : f_crnt + 1'b1;
                        if (f_last) begin
                            n_nxt = n_last ? '0 : n_crnt + 1'b1;
                            if (n_last) begin
                                state_nxt = OUTER_LOOP;
                            end
                        end
                    end
                end
            end
            OUTER_LOOP: begin
                if (!i_await) begin
                    state_nxt = INNER_LOOP;
                    t_nxt     = t_last ? '0 : t_crnt + 1'b1;
                    if (t_last) begin
                        e_nxt = e_last ? '0 : e_crnt + 1'b1;
                        if (e_last) begin
                            state_nxt = DONE;
                        end
                    end
                end
            end
            DONE: begin
                state_nxt = IDLE;
                base_nxt  = (base_step == i_m) ? '0 : base_step; // rotate over the channels.
            end
            default: state_nxt = IDLE;
        endcase
    end

    assign o_busy      = (state_crnt != IDLE);
    assign o_done      = (state_crnt == DONE);
    assign o_idx_valid = (state_crnt == INNER_LOOP) && !i_await;

    assign o_psum_index    = n_crnt;
    assign o_channel_index = base_crnt + M_W'(p_crnt) + group_offset;
    assign o_row_index     = e_crnt;
    assign o_col_index     = f_crnt;

endmodule

// ==== psum_accumulator.sv ====
`timescale 1ns/10ps
`include "psum_params.svh"

module psum_accumulator
    import psum_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        i_start,
    input  logic                        i_idx_valid,
    input  logic [`PSUM_E_WIDTH-1:0]    i_row_index,
    input  logic [`PSUM_F_WIDTH-1:0]    i_col_index,
    input  psum_t                       i_psum_data,
    input  logic                        i_rd_strobe,
    input  buf_addr_t                   i_rd_addr,
    output acc_t                        o_rd_data,
    output logic                        o_rd_valid
);

    localparam int E_W  = `PSUM_E_WIDTH;
    localparam int COLS = 1 << `PSUM_F_WIDTH;
    localparam int ROWS = `PSUM_BUF_DEPTH / COLS;

    acc_t buf_mem [ROWS][COLS];

    logic                     clr_active;
    logic [`PSUM_E_WIDTH-1:0] clr_row;
    logic                     clr_en;
    logic [`PSUM_E_WIDTH-1:0] clr_row_sel;
    logic                     clr_hit;
    acc_t                     psum_ext;
    acc_t                     acc_next;
    logic [`PSUM_E_WIDTH-1:0] rd_row;
    logic [`PSUM_F_WIDTH-1:0] rd_col;

    // the sweep clears a whole row per cycle, starting with row 0 on the start pulse.
    // a row takes at least two cycles in the generator, so the sweep keeps ahead.
    assign clr_en      = i_start || clr_active;
    assign clr_row_sel = i_start ? '0 : clr_row;
    assign clr_hit     = clr_en && (clr_row_sel == i_row_index);

    assign psum_ext = acc_t'(i_psum_data);
    assign acc_next = clr_hit ? psum_ext : buf_mem[i_row_index][i_col_index] + psum_ext;

    assign rd_row = i_rd_addr[$bits(buf_addr_t)-1 -: `PSUM_E_WIDTH];
    assign rd_col = i_rd_addr[`PSUM_F_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            clr_active <= 1'b0;
            clr_row    <= '0;
        end else if (i_start) begin
            clr_active <= 1'b1;
            clr_row    <= E_W'(1);
        end else if (clr_active) begin
            clr_row <= clr_row + 1'b1;
            if (clr_row == E_W'(ROWS - 1)) begin
                clr_active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clr_en) begin
            for (int c = 0; c < COLS; c++) begin
                buf_mem[clr_row_sel][c] <= '0;
            end
        end
        if (i_idx_valid) begin
            buf_mem[i_row_index][i_col_index] <= acc_next; // overrides a clear of the same entry.
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            o_rd_valid <= 1'b0;
        end else begin
            o_rd_valid <= i_rd_strobe;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rd_strobe) begin
            o_rd_data <= buf_mem[rd_row][rd_col];
        end
    end

endmodule

// ==== psum_top.sv ====
`timescale 1ns/10ps
`include "psum_params.svh"

module psum_top
    import psum_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        i_cfg_strobe,
    input  cfg_op_e                     i_cfg_op,
    input  logic [`PSUM_CFG_WIDTH-1:0]  i_cfg_data,
    output logic                        o_cfg_error,
    input  logic                        i_await,
    output logic                        o_busy,
    output logic                        o_done,
    output logic                        o_idx_valid,
    output logic [`PSUM_N_WIDTH-1:0]    o_psum_index,
    output logic [`PSUM_M_WIDTH-1:0]    o_channel_index,
    output logic [`PSUM_E_WIDTH-1:0]    o_row_index,
    output logic [`PSUM_F_WIDTH-1:0]    o_col_index,
    input  psum_t                       i_psum_data,
    input  logic                        i_rd_strobe,
    input  buf_addr_t                   i_rd_addr,
    output acc_t                        o_rd_data,
    output logic                        o_rd_valid
);

    logic [`PSUM_F_WIDTH-1:0] shape_f;
    logic [`PSUM_M_WIDTH-1:0] shape_m;
    logic [`PSUM_N_WIDTH-1:0] shape_n;
    logic [`PSUM_E_WIDTH-1:0] shape_e;
    logic [`PSUM_P_WIDTH-1:0] shape_p;
    logic [`PSUM_T_WIDTH-1:0] shape_t;
    logic                     start_pulse;

    layer_config_regs u_cfg (
        .clk          (clk),
        .reset        (reset),
        .i_cfg_strobe (i_cfg_strobe),
        .i_cfg_op     (i_cfg_op),
        .i_cfg_data   (i_cfg_data),
        .i_gen_busy   (o_busy),
        .o_shape_f    (shape_f),
        .o_shape_m    (shape_m),
        .o_shape_n    (shape_n),
        .o_shape_e    (shape_e),
        .o_shape_p    (shape_p),
        .o_shape_t    (shape_t),
        .o_start      (start_pulse),
        .o_cfg_error  (o_cfg_error)
    );

    psum_index_generator u_gen (
        .clk             (clk),
        .reset           (reset),
        .i_start         (start_pulse),
        .i_await         (i_await),
        .i_f             (shape_f),
        .i_m             (shape_m),
        .i_n             (shape_n),
        .i_e             (shape_e),
        .i_p             (shape_p),
        .i_t             (shape_t),
        .o_busy          (o_busy),
        .o_done          (o_done),
        .o_idx_valid     (o_idx_valid),
        .o_psum_index    (o_psum_index),
        .o_channel_index (o_channel_index),
        .o_row_index     (o_row_index),
        .o_col_index     (o_col_index)
    );

    psum_accumulator u_acc (
        .clk         (clk),
        .reset       (reset),
        .i_start     (start_pulse),
        .i_idx_valid (o_idx_valid),
        .i_row_index (o_row_index),
        .i_col_index (o_col_index),
        .i_psum_data (i_psum_data),
        .i_rd_strobe (i_rd_strobe),
        .i_rd_addr   (i_rd_addr),
        .o_rd_data   (o_rd_data),
        .o_rd_valid  (o_rd_valid)
    );

endmodule

// ==== tb_psum_top.sv ====
`timescale 1ns/10ps
`include "psum_params.svh"

module tb_psum_top
    import psum_pkg::*;
();

    localparam int VEC_WORDS = 12;  // mode, six shape fields, await flag, four readback addresses.
    localparam int MAX_TESTS = 32;
    localparam int M_W       = `PSUM_M_WIDTH;

    typedef struct packed {
        logic [`PSUM_N_WIDTH-1:0] n;
        logic [`PSUM_M_WIDTH-1:0] ch;
        logic [`PSUM_E_WIDTH-1:0] row;
        logic [`PSUM_F_WIDTH-1:0] col;
    } tuple_t;

    logic                        clk;
    logic                        reset;
    logic                        i_cfg_strobe;
    cfg_op_e                     i_cfg_op;
    logic [`PSUM_CFG_WIDTH-1:0]  i_cfg_data;
    logic                        o_cfg_error;
    logic                        i_await;
    logic                        o_busy;
    logic                        o_done;
    logic                        o_idx_valid;
    logic [`PSUM_N_WIDTH-1:0]    o_psum_index;
    logic [`PSUM_M_WIDTH-1:0]    o_channel_index;
    logic [`PSUM_E_WIDTH-1:0]    o_row_index;
    logic [`PSUM_F_WIDTH-1:0]    o_col_index;
    psum_t                       i_psum_data;
    logic                        i_rd_strobe;
    buf_addr_t                   i_rd_addr;
    acc_t                        o_rd_data;
    logic                        o_rd_valid;

    logic [7:0]     vec_mem [0:VEC_WORDS*MAX_TESTS-1];
    logic [31:0]    lfsr_state;
    acc_t           model_buf [0:`PSUM_BUF_DEPTH-1];
    logic [M_W-1:0] model_base;
    tuple_t         want_q [$];
    int             test_errs;
    int             pass_tests;
    int             fail_tests;
    logic           hung;

    psum_top i_dut (
        .clk             (clk),
        .reset           (reset),
        .i_cfg_strobe    (i_cfg_strobe),
        .i_cfg_op        (i_cfg_op),
        .i_cfg_data      (i_cfg_data),
        .o_cfg_error     (o_cfg_error),
        .i_await         (i_await),
        .o_busy          (o_busy),
        .o_done          (o_done),
        .o_idx_valid     (o_idx_valid),
        .o_psum_index    (o_psum_index),
        .o_channel_index (o_channel_index),
        .o_row_index     (o_row_index),
        .o_col_index     (o_col_index),
        .i_psum_data     (i_psum_data),
        .i_rd_strobe     (i_rd_strobe),
        .i_rd_addr       (i_rd_addr),
        .o_rd_data       (o_rd_data),
        .o_rd_valid      (o_rd_valid)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int count, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits       = {bits[30:0], lfsr_state[0]};
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic write_cfg(input cfg_op_e op, input logic [7:0] data);
        tick();
        i_cfg_strobe = 1'b1;
        i_cfg_op     = op;
        i_cfg_data   = data;
        tick();
        i_cfg_strobe = 1'b0;
    endtask

    task automatic check_tuple(input tuple_t got, input tuple_t want);
        if (got.n !== want.n) begin
            $display("Fail o_psum_index: got %h expected %h", got.n, want.n);
            test_errs++;
        end
        if (got.ch !== want.ch) begin
            $display("Fail o_channel_index: got %h expected %h", got.ch, want.ch);
            test_errs++;
        end
        if (got.row !== want.row) begin
            $display("Fail o_row_index: got %h expected %h", got.row, want.row);
            test_errs++;
        end
        if (got.col !== want.col) begin
            $display("Fail o_col_index: got %h expected %h", got.col, want.col);
            test_errs++;
        end
    endtask

    task automatic check_acc(input buf_addr_t addr, input acc_t got, input acc_t want);
        if (got !== want) begin
            $display("Fail o_rd_data at address %h: got %h expected %h", addr, got, want);
            test_errs++;
        end
    endtask

    task automatic check_event(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("Fail %s: got %h expected %h", name, got, want);
            test_errs++;
        end
    endtask

    // reference loop nest, outermost first: e, t, n, F, p.
    task automatic build_tuples(input int f, input int n, input int e, input int p, input int t);
        tuple_t tp;
        want_q.delete();
        for (int ie = 0; ie < e; ie++) begin
            for (int it = 0; it < t; it++) begin
                for (int in = 0; in < n; in++) begin
                    for (int jf = 0; jf < f; jf++) begin
                        for (int ip = 0; ip < p; ip++) begin
                            tp.n   = `PSUM_N_WIDTH'(in);
                            tp.ch  = M_W'(int'(model_base) + ip + it * p);
                            tp.row = `PSUM_E_WIDTH'(ie);
                            tp.col = `PSUM_F_WIDTH'(jf);
                            want_q.push_back(tp);
                        end
                    end
                end
            end
        end
    endtask

    task automatic read_buf(input buf_addr_t addr, output acc_t data, output logic ok);
        int waited;
        tick();
        i_rd_strobe = 1'b1;
        i_rd_addr   = addr;
        tick();
        i_rd_strobe = 1'b0;
        @(negedge clk);
        waited = 0;
        while (!o_rd_valid && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        ok   = o_rd_valid;
        data = o_rd_data;
    endtask

    task automatic run_test(input int idx);
        int             b;
        int             f, m, n, e, p, t;
        int             tuples, seen, limit, cycles, err_pulses;
        logic [7:0]     mode;
        logic           stall;
        logic           done_seen;
        logic [31:0]    bits;
        tuple_t         got;
        tuple_t         want;
        logic [M_W-1:0] step;
        acc_t           rd_data;
        logic           rd_ok;
        buf_addr_t      rd_addr;

        b     = idx * VEC_WORDS;
        mode  = vec_mem[b];
        f     = {24'd0, vec_mem[b+1]};
        m     = {24'd0, vec_mem[b+2]};
        n     = {24'd0, vec_mem[b+3]};
        e     = {24'd0, vec_mem[b+4]};
        p     = {24'd0, vec_mem[b+5]};
        t     = {24'd0, vec_mem[b+6]};
        stall = vec_mem[b+7][0];
        test_errs = 0;

        write_cfg(CFG_F, vec_mem[b+1]);
        write_cfg(CFG_M, vec_mem[b+2]);
        write_cfg(CFG_N, vec_mem[b+3]);
        write_cfg(CFG_E, vec_mem[b+4]);
        write_cfg(CFG_P, vec_mem[b+5]);
        write_cfg(CFG_T, vec_mem[b+6]);
        tick();
        i_cfg_strobe = 1'b1;
        i_cfg_op     = CFG_START;
        tick();
        i_cfg_strobe = 1'b0;
        @(negedge clk);
        check_event("o_cfg_error", o_cfg_error, mode == 8'h01);

        if (mode == 8'h01) begin
            for (int i = 0; i < 4; i++) begin
                tick();
                @(negedge clk);
                check_event("o_busy", o_busy, 1'b0); // a refused start never launches a run.
            end
        end else begin
            foreach (model_buf[a]) model_buf[a] = '0;
            build_tuples(f, n, e, p, t);
            tuples     = want_q.size();
            limit      = 4 * (tuples + e * t) + 64;
            seen       = 0;
            cycles     = 0;
            err_pulses = 0;
            done_seen  = 1'b0;
            while (!done_seen && cycles < limit) begin
                tick();
                i_cfg_strobe = (mode == 8'h02) && (cycles == 2); // second start during the run.
                i_cfg_op     = CFG_START;
                i_await      = 1'b0;
                if (stall) begin
                    draw_bits(2, bits);
                    i_await = &bits[1:0];
                end
                draw_bits(16, bits);
                i_psum_data = bits[15:0];
                @(negedge clk);
                cycles++;
                if (o_cfg_error) err_pulses++;
                check_event("o_busy", o_busy, 1'b1);
                if (o_idx_valid) begin
                    seen++;
                    got.n   = o_psum_index;
                    got.ch  = o_channel_index;
                    got.row = o_row_index;
                    got.col = o_col_index;
                    if (want_q.size() == 0) begin
                        $display("tuple seen after the last expected one in test %0d", idx);
                        test_errs++;
                    end else begin
                        want = want_q.pop_front();
                        check_tuple(got, want);
                        model_buf[{want.row, want.col}] += acc_t'(i_psum_data);
                    end
                end
                done_seen = o_done;
            end
            i_cfg_strobe = 1'b0;
            i_await      = 1'b0;
            if (!done_seen) begin
                $display("timeout: o_done did not rise within %0d cycles in test %0d", limit, idx);
                hung = 1'b1;
                test_errs++;
            end else begin
                if (seen != tuples) begin
                    $display("run ended after %0d tuples instead of %0d", seen, tuples);
                    test_errs++;
                end
                if (err_pulses != ((mode == 8'h02) ? 1 : 0)) begin
                    $display("o_cfg_error pulsed %0d times during the run", err_pulses);
                    test_errs++;
                end
                tick();
                @(negedge clk);
                check_event("o_done", o_done, 1'b0);
                check_event("o_busy", o_busy, 1'b0);
                step       = M_W'(int'(model_base) + p * t);
                model_base = (step == M_W'(m)) ? '0 : step;
                for (int k = 0; k < 4 && !hung; k++) begin
                    rd_addr = vec_mem[b+8+k][$bits(buf_addr_t)-1:0];
                    read_buf(rd_addr, rd_data, rd_ok);
                    if (!rd_ok) begin
                        $display("timeout: no o_rd_valid for address %h in test %0d", rd_addr, idx);
                        hung = 1'b1;
                        test_errs++;
                    end else begin
                        check_acc(rd_addr, rd_data, model_buf[rd_addr]);
                    end
                end
            end
        end

        if (test_errs == 0) begin
            pass_tests++;
            $display("test %0d mode %0h f=%0d m=%0d n=%0d e=%0d p=%0d t=%0d: ok",
                     idx, mode, f, m, n, e, p, t);
        end else begin
            fail_tests++;
            $display("test %0d mode %0h f=%0d m=%0d n=%0d e=%0d p=%0d t=%0d: %0d errors",
                     idx, mode, f, m, n, e, p, t, test_errs);
        end
    endtask

    initial begin
        int idx;
        reset        = 1'b1;
        i_cfg_strobe = 1'b0;
        i_cfg_op     = CFG_F;
        i_cfg_data   = '0;
        i_await      = 1'b0;
        i_psum_data  = '0;
        i_rd_strobe  = 1'b0;
        i_rd_addr    = '0;
        lfsr_state   = 32'hba47_42f6;
        model_base   = '0;
        pass_tests   = 0;
        fail_tests   = 0;
        hung         = 1'b0;
        foreach (vec_mem[a]) vec_mem[a] = 8'hff; // a short file still ends the list.
        $readmemh("psum_input.txt", vec_mem);

        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;
        @(negedge clk);
        test_errs = 0;
        check_event("o_busy", o_busy, 1'b0);
        check_event("o_done", o_done, 1'b0);
        check_event("o_idx_valid", o_idx_valid, 1'b0);
        check_event("o_cfg_error", o_cfg_error, 1'b0);
        check_event("o_rd_valid", o_rd_valid, 1'b0);
        if (test_errs == 0) begin
            pass_tests++;
            $display("reset values: ok");
        end else begin
            fail_tests++;
            $display("reset values: %0d errors", test_errs);
        end

        if (vec_mem[0] == 8'hff) begin
            $display("no test vectors were read from psum_input.txt");
            hung = 1'b1;
        end
        idx = 0;
        while (!hung && idx < MAX_TESTS && vec_mem[idx*VEC_WORDS] != 8'hff) begin
            run_test(idx);
            idx++;
        end

        $display("tests run %0d, passed %0d, failed %0d", pass_tests + fail_tests, pass_tests,
                 fail_tests);
        if (fail_tests == 0 && !hung) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== psum_input.txt ====
// one run per line, all values hex: mode f m n e p t await rd0 rd1 rd2 rd3
// mode 00 is a plain run, 01 expects the start to be refused,
// 02 is a run that also gets a second start while busy. a line holding ff ends the list.
// the readback addresses are {row, col} and include entries that the run never touches.
00 04 0c 02 03 03 02 00 00 01 23 33
00 04 0c 02 03 03 02 01 10 02 13 04
00 04 0c 02 03 03 02 00 22 21 30 05
01 00 0c 02 03 03 02 00 00 00 00 00
01 04 0c 02 03 05 03 00 00 00 00 00
01 04 00 02 03 03 02 00 00 00 00 00
01 04 0c 00 03 03 02 00 00 00 00 00
02 05 10 01 02 02 03 01 00 14 15 20
00 0f 3f 01 07 07 03 00 7e 60 0f 70
00 01 01 01 01 01 01 01 00 01 10 7f
00 03 0f 03 04 05 03 01 32 02 40 33
00 03 0f 03 04 05 03 00 00 12 3f 41
01 03 0f 03 04 05 00 01 00 00 00 00
00 08 18 02 02 02 03 01 17 07 18 20
00 08 18 02 02 02 03 01 00 27 08 11
ff

// ==== list.f ====
+incdir+.
psum_pkg.sv
layer_config_regs.sv
psum_index_generator.sv
psum_accumulator.sv
psum_top.sv
tb_psum_top.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f list.f --top-module tb_psum_top -Mdir obj_dir -o sim_psum

run: compile
	-./obj_dir/sim_psum > sim.log 2>&1
	cat sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
